/* Makefile */
# Verilator build and run of the memory controller testbench

TOP = tb_mem_ctrl

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
		--top-module $(TOP) -f all.f -o $(TOP)

# pass only if the run prints the pass message
run: compile
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; \
		echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

/* all.f */
+incdir+.
mc_pkg.sv
req_queue.sv
cmd_spacing.sv
bank_scheduler.sv
refresh_timer.sv
mem_ctrl_top.sv
tb_clk_gen.sv
tb_mem_ctrl.sv

/* bank_scheduler.sv */
/*
 * bank status and head request sequencing
 * open flag, open row and tRCD/tRP/tRAS/tRC countdowns for all 16 banks,
 * step choice and PRE/ACT/RD/WR issue for the head of the queue
 */
`timescale 1ns/1ns
`include "mc_cfg.svh"

module bank_scheduler (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  head_valid,
	input  mc_pkg::cpu_op_t       head_op,
	input  logic [`MC_ADDR_W-1:0] head_addr,
	output logic                  pop,          // head request completes
	input  logic                  refresh_busy, // tRFC window
	input  logic                  ref_issue,    // REF pulse
	input  logic                  act_ok,
	input  logic                  rd_ok,
	input  logic                  wr_ok,
	output logic [`MC_BG_W-1:0]   want_bg,
	output logic                  cmd_valid,
	output mc_pkg::dram_cmd_t     cmd_op,
	output logic [`MC_BG_W-1:0]   cmd_bg,
	output logic [`MC_BANK_W-1:0] cmd_bank,
	output logic [`MC_ROW_W-1:0]  cmd_row,
	output logic [`MC_COL_W-1:0]  cmd_col
);

	localparam int IDX_W = `MC_BG_W + `MC_BANK_W;
	localparam int NB    = 1 << IDX_W;   // 16 banks

	// countdown load values, zero means the rule is met
	localparam logic [`MC_TIMER_W-1:0] RCD_LD = `MC_TIMER_W'(`MC_T_RCD - 1);
	localparam logic [`MC_TIMER_W-1:0] RP_LD  = `MC_TIMER_W'(`MC_T_RP - 1);
	localparam logic [`MC_TIMER_W-1:0] RAS_LD = `MC_TIMER_W'(`MC_T_RAS - 1);
	localparam logic [`MC_TIMER_W-1:0] RC_LD  = `MC_TIMER_W'(`MC_T_RC - 1);

	logic [`MC_BG_W-1:0]    hd_bg;
	logic [`MC_BANK_W-1:0]  hd_bank;
	logic [`MC_ROW_W-1:0]   hd_row;
	logic [`MC_COL_W-1:0]   hd_col;
	logic [IDX_W-1:0]       cur_idx;     // flat bank index of the head

	logic                   bank_open [NB];
	logic [`MC_ROW_W-1:0]   open_row  [NB];
	logic [`MC_TIMER_W-1:0] rcd_cnt   [NB];
	logic [`MC_TIMER_W-1:0] rp_cnt    [NB];
	logic [`MC_TIMER_W-1:0] ras_cnt   [NB];
	logic [`MC_TIMER_W-1:0] rc_cnt    [NB];

	mc_pkg::bank_step_t     step;
	mc_pkg::dram_cmd_t      iss_op;
	logic                   is_write;
	logic                   step_ok;
	logic                   issue;
	logic                   act_fire;
	logic                   pre_fire;

	// address split
	assign hd_bg   = head_addr[`MC_BG_LSB   +: `MC_BG_W];
	assign hd_bank = head_addr[`MC_BANK_LSB +: `MC_BANK_W];
	assign hd_row  = head_addr[`MC_ROW_LSB  +: `MC_ROW_W];
	assign hd_col  = head_addr[`MC_COL_LSB  +: `MC_COL_W];
	assign cur_idx = {hd_bg, hd_bank};

	assign is_write = (head_op == mc_pkg::DATA_WRITE); // reads and fetches -> RD

	// what the head bank needs next
	always_comb begin
		if (!head_valid)
			step = mc_pkg::STEP_IDLE;
		else if (!bank_open[cur_idx])
			step = mc_pkg::STEP_ACT;
		else if (open_row[cur_idx] == hd_row)
			step = mc_pkg::STEP_COL;  // row hit
		else
			step = mc_pkg::STEP_PRE;  // row conflict
	end

	// readiness of that step against bank and global timing
	always_comb begin
		iss_op  = mc_pkg::RD;
		step_ok = 1'b0;
		case (step)
			mc_pkg::STEP_PRE: begin
				iss_op  = mc_pkg::PRE;
				step_ok = (ras_cnt[cur_idx] == '0);
			end
			mc_pkg::STEP_ACT: begin
				iss_op  = mc_pkg::ACT;
				step_ok = (rp_cnt[cur_idx] == '0) && (rc_cnt[cur_idx] == '0) && act_ok;
			end
			mc_pkg::STEP_COL: begin
				iss_op  = is_write ? mc_pkg::WR : mc_pkg::RD;
				step_ok = (rcd_cnt[cur_idx] == '0) && (is_write ? wr_ok : rd_ok);
			end
			default: ;   // idle
		endcase
	end

	assign issue    = step_ok && !refresh_busy;     // nothing inside tRFC
	assign act_fire = issue && (iss_op == mc_pkg::ACT);
	assign pre_fire = issue && (iss_op == mc_pkg::PRE);
	assign pop      = issue && (step == mc_pkg::STEP_COL);
	assign want_bg  = hd_bg;

	// command bus, REF comes straight from the refresh timer
	assign cmd_valid = issue || ref_issue;
	assign cmd_op    = ref_issue ? mc_pkg::REF : iss_op;
	assign cmd_bg    = hd_bg;
	assign cmd_bank  = hd_bank;
	assign cmd_row   = hd_row;
	assign cmd_col   = hd_col;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NB; i++) begin
				bank_open[i] <= 1'b0;
				rcd_cnt[i]   <= '0;
				rp_cnt[i]    <= '0;
				ras_cnt[i]   <= '0;
				rc_cnt[i]    <= '0;
			end
		end else begin
			for (int i = 0; i < NB; i++) begin
				if (rcd_cnt[i] != '0)
					rcd_cnt[i] <= rcd_cnt[i] - 1'b1;
				if (rp_cnt[i] != '0)
					rp_cnt[i] <= rp_cnt[i] - 1'b1;
				if (ras_cnt[i] != '0)
					ras_cnt[i] <= ras_cnt[i] - 1'b1;
				if (rc_cnt[i] != '0)
					rc_cnt[i] <= rc_cnt[i] - 1'b1;
				if (ref_issue)
					bank_open[i] <= 1'b0;   // refresh leaves all banks closed
			end
			if (act_fire) begin
				bank_open[cur_idx] <= 1'b1;
				rcd_cnt[cur_idx]   <= RCD_LD;
				ras_cnt[cur_idx]   <= RAS_LD;
				rc_cnt[cur_idx]    <= RC_LD;
			end
			if (pre_fire) begin
				bank_open[cur_idx] <= 1'b0;
				rp_cnt[cur_idx]    <= RP_LD;
			end
		end
	end

	// row latched by ACT, valid while the bank is open
	always_ff @(posedge clk) begin
		if (act_fire)
			open_row[cur_idx] <= hd_row;
	end

	// no ACT to the same bank in the tRAS-1 cycles before a PRE
	for (genvar k = 1; k < `MC_T_RAS; k++) begin : g_ras_chk
		a_pre_ras: assert property (@(posedge clk) disable iff (!rst_n)
			pre_fire |-> !($past(act_fire, k) && ($past(cur_idx, k) == cur_idx)))
			else $error("PRE before tRAS");
	end

endmodule

/* cmd_spacing.sv */
/*
 * global command spacing
 * up-counters since the last ACT and the last column command,
 * tRRD, tCCD and tWTR checks for the bank group asked about
 */
`timescale 1ns/1ns
`include "mc_cfg.svh"

module cmd_spacing (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                issue_valid,  // command going out this cycle
	input  mc_pkg::dram_cmd_t   issue_op,
	input  logic [`MC_BG_W-1:0] issue_bg,
	input  logic [`MC_BG_W-1:0] want_bg,      // group of the pending command
	output logic                act_ok,
	output logic                rd_ok,
	output logic                wr_ok
);

	localparam logic [`MC_TIMER_W-1:0] RRD_S = `MC_TIMER_W'(`MC_T_RRD_S);
	localparam logic [`MC_TIMER_W-1:0] RRD_L = `MC_TIMER_W'(`MC_T_RRD_L);
	localparam logic [`MC_TIMER_W-1:0] CCD_S = `MC_TIMER_W'(`MC_T_CCD_S);
	localparam logic [`MC_TIMER_W-1:0] CCD_L = `MC_TIMER_W'(`MC_T_CCD_L);
	localparam logic [`MC_TIMER_W-1:0] WTR_S = `MC_TIMER_W'(`MC_T_WTR_S);
	localparam logic [`MC_TIMER_W-1:0] WTR_L = `MC_TIMER_W'(`MC_T_WTR_L);

	logic [`MC_TIMER_W-1:0] act_cnt;   // cycles since last ACT
	logic [`MC_TIMER_W-1:0] col_cnt;   // cycles since last RD/WR
	logic [`MC_BG_W-1:0]    act_bg;
	logic [`MC_BG_W-1:0]    col_bg;
	logic                   col_wr;    // last column command was a write
	logic                   same_act_bg;
	logic                   same_col_bg;
	logic                   ccd_ok;
	logic                   wtr_ok;

	assign same_act_bg = (want_bg == act_bg);
	assign same_col_bg = (want_bg == col_bg);

	assign act_ok = act_cnt >= (same_act_bg ? RRD_L : RRD_S);
	assign ccd_ok = col_cnt >= (same_col_bg ? CCD_L : CCD_S);
	assign wtr_ok = !col_wr || (col_cnt >= (same_col_bg ? WTR_L : WTR_S)); // only after a write

	assign wr_ok = ccd_ok;
	assign rd_ok = ccd_ok && wtr_ok;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			act_cnt <= '1;    // saturated, first command may go at once
			col_cnt <= '1;
			act_bg  <= '0;
			col_bg  <= '0;
			col_wr  <= 1'b0;
		end else begin
			if (act_cnt != '1)
				act_cnt <= act_cnt + 1'b1;
			if (col_cnt != '1)
				col_cnt <= col_cnt + 1'b1;

			// restart on issue, value k means k cycles since the command
			if (issue_valid) begin
				case (issue_op)
					mc_pkg::ACT: begin
						act_cnt <= `MC_TIMER_W'(1);
						act_bg  <= issue_bg;
					end
					mc_pkg::RD, mc_pkg::WR: begin
						col_cnt <= `MC_TIMER_W'(1);
						col_bg  <= issue_bg;
						col_wr  <= (issue_op == mc_pkg::WR);
					end
					default: ;        // PRE and REF do not count here
				endcase
			end
		end
	end

	// the scheduler never activates ahead of the tRRD window
	a_act_spaced: assert property (@(posedge clk) disable iff (!rst_n)
		(issue_valid && issue_op == mc_pkg::ACT) |-> (want_bg == issue_bg) && act_ok)
		else $error("ACT issued inside tRRD");

endmodule

/* mc_cfg.svh */
/*
 * controller configuration macros
 * queue depth, request address field layout,
 * DRAM timing constants in clk cycles and the timer width
 */
`ifndef MC_CFG_SVH
`define MC_CFG_SVH

// request queue
`define MC_QUEUE_DEPTH 8

// request address layout
`define MC_ADDR_W      32
`define MC_COL_LSB     0
`define MC_COL_W       10
`define MC_BG_LSB      10   // bank group sits right above the column
`define MC_BG_W        2
`define MC_BANK_LSB    12
`define MC_BANK_W      2
`define MC_ROW_LSB     14
`define MC_ROW_W       16

// per bank timing
`define MC_T_RCD       4    // act to column command
`define MC_T_RP        4    // pre to act
`define MC_T_RAS       10   // act to pre
`define MC_T_RC        14   // act to act, same bank

// spacing between banks, short = other group, long = same group
`define MC_T_RRD_S     2
`define MC_T_RRD_L     4
`define MC_T_CCD_S     2
`define MC_T_CCD_L     4
`define MC_T_WTR_S     3
`define MC_T_WTR_L     6

// refresh
`define MC_T_REFI      400
`define MC_T_RFC       30

// width of the spacing and bank countdown counters
`define MC_TIMER_W     8

`endif

/* mc_pkg.sv */
/*
 * shared controller types
 * cpu request opcode, DRAM command encoding and the bank step
 */
package mc_pkg;

	// opcode of a cpu request
	typedef enum logic [1:0] {
		DATA_READ    = 2'd0,
		DATA_WRITE   = 2'd1,
		OPCODE_FETCH = 2'd2
	} cpu_op_t;

	// command on the DRAM command bus
	typedef enum logic [2:0] {
		RD  = 3'd0,   // idle value of the bus
		WR  = 3'd1,
		ACT = 3'd2,
		PRE = 3'd3,
		REF = 3'd4
	} dram_cmd_t;

	// what the bank of the head request needs next
	typedef enum logic [1:0] {
		STEP_IDLE = 2'd0,  // nothing queued
		STEP_PRE  = 2'd1,  // wrong row open
		STEP_ACT  = 2'd2,  // bank closed
		STEP_COL  = 2'd3   // row hit
	} bank_step_t;

endpackage

/* mem_ctrl_top.sv */
/*
 * memory controller command side, top level
 * request queue, bank scheduler, command spacing and refresh timer
 */
`timescale 1ns/1ns
`include "mc_cfg.svh"

module mem_ctrl_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  req_valid,
	input  mc_pkg::cpu_op_t       req_op,
	input  logic [`MC_ADDR_W-1:0] req_addr,
	output logic                  queue_full,
	output logic                  cmd_valid,
	output mc_pkg::dram_cmd_t     cmd_op,
	output logic [`MC_BG_W-1:0]   cmd_bg,
	output logic [`MC_BANK_W-1:0] cmd_bank,
	output logic [`MC_ROW_W-1:0]  cmd_row,
	output logic [`MC_COL_W-1:0]  cmd_col
);

	// queue head
	logic                  head_valid;
	mc_pkg::cpu_op_t       head_op;
	logic [`MC_ADDR_W-1:0] head_addr;
	logic                  pop;
	// refresh
	logic                  ref_issue;
	logic                  refresh_busy;
	// spacing handshake
	logic [`MC_BG_W-1:0]   want_bg;
	logic                  act_ok;
	logic                  rd_ok;
	logic                  wr_ok;

	req_queue req_queue_i (
		.clk, .rst_n, .req_valid, .req_op, .req_addr, .pop,
		.head_valid, .head_op, .head_addr, .queue_full
	);

	// the issued command is the command bus itself
	cmd_spacing cmd_spacing_i (
		.clk, .rst_n,
		.issue_valid (cmd_valid),
		.issue_op    (cmd_op),
		.issue_bg    (cmd_bg),
		.want_bg, .act_ok, .rd_ok, .wr_ok
	);

	bank_scheduler bank_scheduler_i (
		.clk, .rst_n, .head_valid, .head_op, .head_addr, .pop,
		.refresh_busy, .ref_issue, .act_ok, .rd_ok, .wr_ok, .want_bg,
		.cmd_valid, .cmd_op, .cmd_bg, .cmd_bank, .cmd_row, .cmd_col
	);

	refresh_timer refresh_timer_i (
		.clk, .rst_n, .ref_issue, .refresh_busy
	);

endmodule

/* refresh_timer.sv */
/*
 * refresh timer
 * tREFI interval count, REF pulse and the tRFC busy window
 */
`timescale 1ns/1ns
`include "mc_cfg.svh"

module refresh_timer (
	input  logic clk,
	input  logic rst_n,
	output logic ref_issue,     // one cycle, REF on the bus
	output logic refresh_busy   // high for tRFC cycles from REF
);

	localparam int REF_W = $clog2(`MC_T_REFI);
	localparam logic [REF_W-1:0] REFI_LD = REF_W'(`MC_T_REFI - 1);
	localparam logic [REF_W-1:0] RFC_LD  = REF_W'(`MC_T_RFC - 1);

	logic [REF_W-1:0] ref_cnt;   // shared by the interval and the window

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ref_cnt      <= REFI_LD;
			ref_issue    <= 1'b0;
			refresh_busy <= 1'b0;
		end else begin
			ref_issue <= 1'b0;
			if (!refresh_busy) begin
				if (ref_cnt == '0) begin
					ref_issue    <= 1'b1;     // interval done, refresh now
					refresh_busy <= 1'b1;
					ref_cnt      <= RFC_LD;
				end else begin
					ref_cnt <= ref_cnt - 1'b1;
				end
			end else begin
				if (ref_cnt == '0) begin
					refresh_busy <= 1'b0;     // tRFC over, next interval starts
					ref_cnt      <= REFI_LD;
				end else begin
					ref_cnt <= ref_cnt - 1'b1;
				end
			end
		end
	end

	// busy window spans exactly tRFC cycles starting with the REF cycle
	a_rfc_window: assert property (@(posedge clk) disable iff (!rst_n)
		ref_issue |-> ##(`MC_T_RFC - 1) refresh_busy ##1 !refresh_busy)
		else $error("tRFC window has the wrong length");

endmodule

/* req_queue.sv */
/*
 * in-order request queue
 * circular buffer with push/pop in the same cycle, count based full flag
 */
`timescale 1ns/1ns
`include "mc_cfg.svh"

module req_queue (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  req_valid,   // single cycle request strobe
	input  mc_pkg::cpu_op_t       req_op,
	input  logic [`MC_ADDR_W-1:0] req_addr,
	input  logic                  pop,         // head done, from scheduler
	output logic                  head_valid,
	output mc_pkg::cpu_op_t       head_op,
	output logic [`MC_ADDR_W-1:0] head_addr,
	output logic                  queue_full
);

	localparam int PTR_W = $clog2(`MC_QUEUE_DEPTH);
	localparam int CNT_W = $clog2(`MC_QUEUE_DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`MC_QUEUE_DEPTH - 1);
	localparam logic [CNT_W-1:0] DEPTH = CNT_W'(`MC_QUEUE_DEPTH);

	mc_pkg::cpu_op_t       op_mem   [`MC_QUEUE_DEPTH];
	logic [`MC_ADDR_W-1:0] addr_mem [`MC_QUEUE_DEPTH];
	logic [PTR_W-1:0]      wr_ptr;
	logic [PTR_W-1:0]      rd_ptr;
	logic [CNT_W-1:0]      count;
	logic                  do_push;
	logic                  do_pop;

	assign head_valid = (count != '0);
	assign queue_full = (count == DEPTH);
	assign do_push    = req_valid && !queue_full; // a strobe on full is dropped
	assign do_pop     = pop && head_valid;
	assign head_op    = op_mem[rd_ptr];
	assign head_addr  = addr_mem[rd_ptr];

	// entry storage
	always_ff @(posedge clk) begin
		if (do_push) begin
			op_mem[wr_ptr]   <= req_op;
			addr_mem[wr_ptr] <= req_addr;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1; // wrap
			if (do_pop)
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;        // both or neither
			endcase
		end
	end

	// producer must honour queue_full
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
		req_valid |-> !queue_full)
		else $error("request strobe while queue full");

	// scheduler only completes a request that is queued
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> head_valid)
		else $error("pop on empty queue");

endmodule

/* tb_clk_gen.sv */
/*
 * testbench clock source
 * free running clk with a 40 ns period
 */
`timescale 1ns/1ns

module tb_clk_gen #(
	parameter int PERIOD = 40   // ns
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;   // 20 ns low, 20 ns high
	end

endmodule

/* tb_mem_ctrl.sv */
/*
 * testbench for the controller top level
 * stimulus, reference model of requests, banks and spacing,
 * checking assertions, per test report and watchdog
 */
`timescale 1ns/1ns
`include "mc_cfg.svh"

module tb_mem_ctrl;

	localparam int N_RAND = 64;                 // random traffic
	localparam int N_SEQ  = 6;                  // row sequencing
	localparam int N_REF  = 8;                  // around a refresh
	localparam int N_BP   = `MC_QUEUE_DEPTH;    // burst into a full queue
	localparam int WATCHDOG_CYC = (N_RAND + N_SEQ + N_REF + N_BP) * 50 + 2000;
	localparam int IDX_W = `MC_BG_W + `MC_BANK_W;
	localparam int NB    = 1 << IDX_W;
	localparam int LONG_AGO = -1000;           // no command seen yet

	logic                  clk;
	logic                  rst_n;
	logic                  req_valid;
	mc_pkg::cpu_op_t       req_op;
	logic [`MC_ADDR_W-1:0] req_addr;
	logic                  queue_full;
	logic                  cmd_valid;
	mc_pkg::dram_cmd_t     cmd_op;
	logic [`MC_BG_W-1:0]   cmd_bg;
	logic [`MC_BANK_W-1:0] cmd_bank;
	logic [`MC_ROW_W-1:0]  cmd_row;
	logic [`MC_COL_W-1:0]  cmd_col;

	// request fifo of the model, pushed by the stimulus, popped on RD/WR
	logic [`MC_ADDR_W-1:0] fifo_addr [64];
	mc_pkg::cpu_op_t       fifo_op   [64];
	logic [31:0]           fifo_wr;
	logic [31:0]           fifo_rd;
	logic                  exp_valid;
	logic [`MC_ADDR_W-1:0] exp_addr;
	logic [`MC_BG_W-1:0]   exp_bg;
	logic [`MC_BANK_W-1:0] exp_bank;
	logic [`MC_ROW_W-1:0]  exp_row;
	logic [`MC_COL_W-1:0]  exp_col;
	mc_pkg::dram_cmd_t     exp_cmd;

	// bank and global state seen on the command bus
	logic                  m_open     [NB];
	logic [`MC_ROW_W-1:0]  m_row      [NB];
	int                    m_last_act [NB];
	int                    m_last_pre [NB];
	int                    cyc;
	int                    g_last_act;
	int                    g_last_col;
	logic [`MC_BG_W-1:0]   g_act_bg;
	logic [`MC_BG_W-1:0]   g_col_bg;
	logic                  g_col_wr;
	int                    last_ref;
	int                    next_ref;
	logic                  ref_seen;
	int                    refs;
	int                    done_cnt;
	int                    chk_err = 0;   // assertion failures
	int                    proc_err = 0;  // procedural check failures

	// decoded command
	logic [IDX_W-1:0]      c_idx;
	logic                  any_cmd;
	logic                  act_c;
	logic                  pre_c;
	logic                  col_c;
	logic                  rd_c;
	logic                  ref_c;
	int                    bank_act_gap;
	int                    bank_pre_gap;
	int                    act_gap;
	int                    col_gap;
	int                    rrd_min;
	int                    ccd_min;
	int                    wtr_min;

	tb_clk_gen clk_gen_i (.clk(clk));

	mem_ctrl_top dut_i (
		.clk, .rst_n, .req_valid, .req_op, .req_addr, .queue_full,
		.cmd_valid, .cmd_op, .cmd_bg, .cmd_bank, .cmd_row, .cmd_col
	);

	assign exp_valid = (fifo_rd != fifo_wr);
	assign exp_addr  = fifo_addr[fifo_rd[5:0]];   // oldest unfinished request
	assign exp_bg    = exp_addr[`MC_BG_LSB +: `MC_BG_W];
	assign exp_bank  = exp_addr[`MC_BANK_LSB +: `MC_BANK_W];
	assign exp_row   = exp_addr[`MC_ROW_LSB +: `MC_ROW_W];
	assign exp_col   = exp_addr[`MC_COL_LSB +: `MC_COL_W];
	assign exp_cmd   = (fifo_op[fifo_rd[5:0]] == mc_pkg::DATA_WRITE) ? mc_pkg::WR : mc_pkg::RD;

	assign c_idx   = {cmd_bg, cmd_bank};
	assign any_cmd = cmd_valid && (cmd_op != mc_pkg::REF);
	assign act_c   = cmd_valid && (cmd_op == mc_pkg::ACT);
	assign pre_c   = cmd_valid && (cmd_op == mc_pkg::PRE);
	assign rd_c    = cmd_valid && (cmd_op == mc_pkg::RD);
	assign col_c   = rd_c || (cmd_valid && (cmd_op == mc_pkg::WR));
	assign ref_c   = cmd_valid && (cmd_op == mc_pkg::REF);

	assign bank_act_gap = cyc - m_last_act[c_idx];
	assign bank_pre_gap = cyc - m_last_pre[c_idx];
	assign act_gap      = cyc - g_last_act;
	assign col_gap      = cyc - g_last_col;
	assign rrd_min = (cmd_bg == g_act_bg) ? `MC_T_RRD_L : `MC_T_RRD_S;  // long within a group
	assign ccd_min = (cmd_bg == g_col_bg) ? `MC_T_CCD_L : `MC_T_CCD_S;
	assign wtr_min = (cmd_bg == g_col_bg) ? `MC_T_WTR_L : `MC_T_WTR_S;

	// model update, a command counts at the edge that ends its cycle
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NB; i++) begin
				m_open[i]     <= 1'b0;
				m_row[i]      <= '0;
				m_last_act[i] <= LONG_AGO;
				m_last_pre[i] <= LONG_AGO;
			end
			cyc        <= 0;
			g_last_act <= LONG_AGO;
			g_last_col <= LONG_AGO;
			g_act_bg   <= '0;
			g_col_bg   <= '0;
			g_col_wr   <= 1'b0;
			last_ref   <= LONG_AGO;
			next_ref   <= `MC_T_REFI;   // first REF after one full interval
			ref_seen   <= 1'b0;
			refs       <= 0;
			done_cnt   <= 0;
			fifo_rd    <= '0;
		end else begin
			cyc <= cyc + 1;
			if (act_c) begin
				m_open[c_idx]     <= 1'b1;
				m_row[c_idx]      <= cmd_row;
				m_last_act[c_idx] <= cyc;
				g_last_act        <= cyc;
				g_act_bg          <= cmd_bg;
			end
			if (pre_c) begin
				m_open[c_idx]     <= 1'b0;
				m_last_pre[c_idx] <= cyc;
			end
			if (col_c) begin
				g_last_col <= cyc;
				g_col_bg   <= cmd_bg;
				g_col_wr   <= !rd_c;
				fifo_rd    <= fifo_rd + 32'd1;   // head request done
				done_cnt   <= done_cnt + 1;
			end
			if (ref_c) begin
				for (int i = 0; i < NB; i++)
					m_open[i] <= 1'b0;              // all banks closed
				last_ref <= cyc;
				next_ref <= cyc + `MC_T_RFC + `MC_T_REFI;
				ref_seen <= 1'b1;
				refs     <= refs + 1;
			end
		end
	end

	task automatic log_mismatch(input string sig, input int got, input int exp);
		$display("Error at %0t: %s got %0d expected %0d", $time, sig, got, exp);
		chk_err++;
	endtask

	task automatic log_violation(input string what);
		$display("Error at %0t: %s", $time, what);
		chk_err++;
	endtask

	// order and completeness
	a_pending: assert property (@(posedge clk) disable iff (!rst_n) any_cmd |-> exp_valid)
		else log_violation("command issued with no request pending");
	a_bg: assert property (@(posedge clk) disable iff (!rst_n) any_cmd |-> cmd_bg == exp_bg)
		else log_mismatch("cmd_bg", int'($sampled(cmd_bg)), int'($sampled(exp_bg)));
	a_bank: assert property (@(posedge clk) disable iff (!rst_n) any_cmd |-> cmd_bank == exp_bank)
		else log_mismatch("cmd_bank", int'($sampled(cmd_bank)), int'($sampled(exp_bank)));
	a_row: assert property (@(posedge clk) disable iff (!rst_n) act_c |-> cmd_row == exp_row)
		else log_mismatch("cmd_row", int'($sampled(cmd_row)), int'($sampled(exp_row)));
	a_col: assert property (@(posedge clk) disable iff (!rst_n) col_c |-> cmd_col == exp_col)
		else log_mismatch("cmd_col", int'($sampled(cmd_col)), int'($sampled(exp_col)));
	a_op: assert property (@(posedge clk) disable iff (!rst_n) col_c |-> cmd_op == exp_cmd)
		else log_mismatch("cmd_op", int'($sampled(cmd_op)), int'($sampled(exp_cmd)));

	// row sequencing, also covers ACT first after a refresh
	a_act_closed: assert property (@(posedge clk) disable iff (!rst_n) act_c |-> !m_open[c_idx])
		else log_violation("ACT to a bank that is already open");
	a_pre_miss: assert property (@(posedge clk) disable iff (!rst_n)
		pre_c |-> m_open[c_idx] && m_row[c_idx] != exp_row)
		else log_violation("PRE to a closed bank or to the requested row");
	a_col_hit: assert property (@(posedge clk) disable iff (!rst_n)
		col_c |-> m_open[c_idx] && m_row[c_idx] == exp_row)
		else log_violation("column command without the requested row open");

	// per bank timing
	a_rcd: assert property (@(posedge clk) disable iff (!rst_n)
		col_c |-> bank_act_gap >= `MC_T_RCD)
		else log_violation($sformatf("ACT to column gap %0d below tRCD", $sampled(bank_act_gap)));
	a_rp: assert property (@(posedge clk) disable iff (!rst_n) act_c |-> bank_pre_gap >= `MC_T_RP)
		else log_violation($sformatf("PRE to ACT gap %0d below tRP", $sampled(bank_pre_gap)));
	a_ras: assert property (@(posedge clk) disable iff (!rst_n)
		pre_c |-> bank_act_gap >= `MC_T_RAS)
		else log_violation($sformatf("ACT to PRE gap %0d below tRAS", $sampled(bank_act_gap)));
	a_rc: assert property (@(posedge clk) disable iff (!rst_n) act_c |-> bank_act_gap >= `MC_T_RC)
		else log_violation($sformatf("ACT to ACT gap %0d below tRC", $sampled(bank_act_gap)));

	// spacing across banks
	a_rrd: assert property (@(posedge clk) disable iff (!rst_n) act_c |-> act_gap >= rrd_min)
		else log_violation($sformatf("ACT gap %0d below tRRD %0d", $sampled(act_gap),
			$sampled(rrd_min)));
	a_ccd: assert property (@(posedge clk) disable iff (!rst_n) col_c |-> col_gap >= ccd_min)
		else log_violation($sformatf("column gap %0d below tCCD %0d", $sampled(col_gap),
			$sampled(ccd_min)));
	a_wtr: assert property (@(posedge clk) disable iff (!rst_n)
		(rd_c && g_col_wr) |-> col_gap >= wtr_min)
		else log_violation($sformatf("write to read gap %0d below tWTR %0d", $sampled(col_gap),
			$sampled(wtr_min)));

	// refresh schedule and the quiet window
	a_ref_time: assert property (@(posedge clk) disable iff (!rst_n) ref_c |-> cyc == next_ref)
		else log_mismatch("REF cycle", $sampled(cyc), $sampled(next_ref));
	a_ref_due: assert property (@(posedge clk) disable iff (!rst_n) (cyc == next_ref) |-> ref_c)
		else log_violation("REF missing at its due cycle");
	a_rfc: assert property (@(posedge clk) disable iff (!rst_n)
		(any_cmd && ref_seen) |-> cyc - last_ref >= `MC_T_RFC)
		else log_violation("command issued inside the tRFC window");

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [`MC_ADDR_W-1:0] make_addr(input logic [`MC_ROW_W-1:0] row,
		input logic [`MC_BG_W-1:0] bg, input logic [`MC_BANK_W-1:0] bank,
		input logic [`MC_COL_W-1:0] col);
		logic [`MC_ADDR_W-1:0] a;
		a = '0;
		a[`MC_ROW_LSB +: `MC_ROW_W]   = row;
		a[`MC_BG_LSB +: `MC_BG_W]     = bg;
		a[`MC_BANK_LSB +: `MC_BANK_W] = bank;
		a[`MC_COL_LSB +: `MC_COL_W]   = col;
		return a;
	endfunction

	// call at a falling edge, returns one falling edge later with the strobe low
	task automatic send_req(input mc_pkg::cpu_op_t op, input logic [`MC_ADDR_W-1:0] addr);
		while (queue_full)
			@(negedge clk);   // producer waits on a full queue
		req_valid = 1'b1;
		req_op    = op;
		req_addr  = addr;
		fifo_addr[fifo_wr[5:0]] = addr;
		fifo_op[fifo_wr[5:0]]   = op;
		fifo_wr = fifo_wr + 32'd1;
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	task automatic wait_idle();
		while (fifo_rd != fifo_wr)
			@(negedge clk);
		repeat (2) @(negedge clk);
	endtask

	task automatic wait_refresh();
		int n;
		n = refs;
		while (refs == n)
			@(negedge clk);
	endtask

	task automatic report_test(input string name, input int errs_before);
		int n;
		n = chk_err + proc_err - errs_before;
		if (n == 0)
			$display("test %s: finished, no errors", name);
		else
			$display("test %s: finished, %0d errors", name, n);
	endtask

	initial begin
		logic [31:0] rng;
		int errs;
		int n;
		rst_n     = 1'b0;
		req_valid = 1'b0;
		req_op    = mc_pkg::DATA_READ;
		req_addr  = '0;
		fifo_wr   = '0;
		rng       = 32'h7e98_0e9c;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		// random opcodes, few rows so hits, misses and conflicts all occur
		errs = chk_err + proc_err;
		for (int i = 0; i < N_RAND; i++) begin
			rng = xorshift32(rng);
			send_req(mc_pkg::cpu_op_t'(2'(rng % 32'd3)),
				make_addr(16'(rng[5:4]), rng[7:6], rng[9:8], rng[19:10]));
			if (rng[20])
				@(negedge clk);   // idle cycle now and then
		end
		wait_idle();
		report_test("random traffic", errs);

		// miss or conflict, hits, conflict, then back to the first row
		errs = chk_err + proc_err;
		send_req(mc_pkg::DATA_READ, make_addr(16'd300, 2'd2, 2'd1, 10'd5));
		send_req(mc_pkg::DATA_WRITE, make_addr(16'd300, 2'd2, 2'd1, 10'd6));
		send_req(mc_pkg::OPCODE_FETCH, make_addr(16'd300, 2'd2, 2'd1, 10'd7));
		send_req(mc_pkg::DATA_READ, make_addr(16'd301, 2'd2, 2'd1, 10'd8));
		send_req(mc_pkg::DATA_WRITE, make_addr(16'd301, 2'd2, 2'd1, 10'd9));
		send_req(mc_pkg::DATA_READ, make_addr(16'd300, 2'd2, 2'd1, 10'd10));
		wait_idle();
		report_test("row sequencing", errs);

		// open one bank per group, refresh, then the same rows again
		errs = chk_err + proc_err;
		for (int i = 0; i < N_REF / 2; i++)
			send_req(mc_pkg::DATA_WRITE, make_addr(16'(40 + i), 2'(i), 2'd0, 10'(i)));
		wait_idle();
		wait_refresh();
		for (int i = 0; i < N_REF / 2; i++)
			send_req(mc_pkg::DATA_READ, make_addr(16'(40 + i), 2'(i), 2'd0, 10'(i)));
		wait_idle();
		report_test("refresh", errs);

		// burst inside the tRFC window, nothing can drain
		errs = chk_err + proc_err;
		wait_refresh();
		for (int i = 0; i < N_BP; i++)
			send_req(mc_pkg::DATA_READ, make_addr(16'(500 + i), 2'd1, 2'd3, 10'(i)));
		if (!queue_full) begin
			$display("Error at %0t: queue_full stayed low with %0d requests queued", $time, N_BP);
			proc_err++;
		end
		n = done_cnt;
		while (done_cnt == n)
			@(negedge clk);
		if (queue_full) begin
			$display("Error at %0t: queue_full still high after the first request completed",
				$time);
			proc_err++;
		end
		wait_idle();
		report_test("back-pressure", errs);

		$display("summary: 4 tests, %0d requests completed, %0d refreshes, %0d errors",
			done_cnt, refs, chk_err + proc_err);
		if (chk_err + proc_err == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// bound on the whole run
	initial begin
		repeat (WATCHDOG_CYC) @(posedge clk);
		$display("watchdog expired after %0d cycles with requests still pending", WATCHDOG_CYC);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
